/* hdl/dcache_macros.svh */
// Cache geometry and bus widths, included by the RTL and the testbench wherever sizes are needed
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ====================
// Geometry
// ====================

// Ways per set
`define DC_WAYS 4

// Sets in the cache, indexed by the low word address bits
`define DC_SETS 4

// ====================
// Bus widths
// ====================

// Word address width on both the CPU and the memory side
`define DC_AW 10
// Data word width
`define DC_DW 32

`endif

/* hdl/mem_req_pkg.sv */
// Memory request codes and controller state encoding, referenced by scoped name in the cache RTL
`default_nettype none

package mem_req_pkg;

	// Request function code as issued by the load/store unit
	typedef logic [6:0] func_t;

	localparam func_t MR_LOAD  = 7'h00;
	localparam func_t MR_STORE = 7'h01;
	// Move-store variant, handled exactly like a plain store
	localparam func_t MR_MOVST = 7'h02;

	// One-hot state encoding of the access state machine
	typedef enum logic [6:0] {
		IDLE       = 7'b000_0001,
		LOOKUP     = 7'b000_0010,
		MEMORY_REQ = 7'b000_0100,
		MEMORY_ACK = 7'b000_1000,
		FILL       = 7'b001_0000,
		REFILL     = 7'b010_0000,
		DONE       = 7'b100_0000
	} state_t;

endpackage

`default_nettype wire

/* hdl/dcache_pkg.sv */
// Cache structure types (way, set, tag and tag entry) derived from the geometry macros
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// Way index within a set
	typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

	// Set index, taken from the low bits of the word address
	typedef logic [$clog2(`DC_SETS)-1:0] set_t;

	// Tag, the address bits above the set index
	typedef logic [`DC_AW-$clog2(`DC_SETS)-1:0] tag_t;

	// One tag array entry
	// The valid bit sits on top so a cleared entry reads as invalid
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

endpackage

`default_nettype wire

/* hdl/dcache_way_if.sv */
// Way selection bundle between the cache controller and the write-way selector
`default_nettype none

interface dcache_way_if;

	// Controller state and the request code being served
	mem_req_pkg::state_t state;
	mem_req_pkg::func_t  func;

	// Lookup result registered at the end of LOOKUP
	logic             hit;
	dcache_pkg::way_t rway;

	// Registered memory acknowledge, high only in MEMORY_ACK
	logic ack;

	// Refill strobe, high for the single FILL cycle
	logic             wr_dc;
	dcache_pkg::way_t lfsr;

	// Way that the next array write goes to
	dcache_pkg::way_t wway;

	modport ctrl (
		output state, func, hit, rway, ack, wr_dc, lfsr,
		input  wway
	);

	modport selector (
		input  state, func, hit, rway, ack, wr_dc, lfsr,
		output wway
	);

endinterface

`default_nettype wire

/* hdl/dcache_way_array.sv */
// Per-set, per-way storage with one write port and a combinational read of all ways in a set
`default_nettype none

`include "dcache_macros.svh"

module dcache_way_array #(
	parameter type entry_t = logic
) (
	input  logic             clk,
	input  logic             rst,
	input  dcache_pkg::set_t set,
	input  logic             wr,
	input  dcache_pkg::way_t wr_way,
	input  entry_t           wr_entry,
	output entry_t           rd_entries [`DC_WAYS]
);

	// Storage is indexed by set first, then by way
	entry_t mem [`DC_SETS][`DC_WAYS];

	// ====================
	// Write port
	// ====================

	// Clearing on reset matters for the tag instance since it drops every valid bit
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					mem[s][w] <= '0;
				end
			end
		end else if (wr) begin
			mem[set][wr_way] <= wr_entry;
		end
	end

	// ====================
	// Read port
	// ====================

	// Every way of the addressed set is presented at once for the tag compare
	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_rd
		assign rd_entries[w] = mem[set][w];
	end

endmodule

`default_nettype wire

/* hdl/dcache_way_select.sv */
// Write-way register that steers every tag and data array write of the cache
`default_nettype none

module dcache_way_select (
	input logic      clk,
	input logic      rst,
	dcache_way_if.selector way
);

	logic store_op;

	// The move-store code is only an alias of the store
	assign store_op = (way.func == mem_req_pkg::MR_STORE) ||
		(way.func == mem_req_pkg::MR_MOVST);

	// ====================
	// Write way register
	// ====================

	// The controller does not qualify any of this and simply writes at wway
	// in the cycle after it changes
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			// Way zero is the starting point after reset
			way.wway <= '0;
		end else begin
			case (way.state)
				// A store hit that memory has acknowledged updates the way it hit
				mem_req_pkg::MEMORY_ACK: begin
					if (way.hit && store_op && way.ack) begin
						way.wway <= way.rway;
					end
				end
				default: ;
			endcase
			// A refill goes to the replacement way
			// This is checked last so it wins over the hit way
			if (way.wr_dc) begin
				way.wway <= way.lfsr;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
// Cache access controller with tag compare, replacement LFSR and memory and CPU handshakes
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        dce,
	// CPU side
	input  logic                        req,
	input  mem_req_pkg::func_t          func,
	input  logic [`DC_AW-1:0]           addr,
	input  logic [`DC_DW-1:0]           wdata,
	output logic                        done,
	output logic [`DC_DW-1:0]           rdata,
	output logic                        hit,
	// Memory side
	output logic                        mem_req,
	output logic                        mem_we,
	output logic [`DC_AW-1:0]           mem_addr,
	output logic [`DC_DW-1:0]           mem_wdata,
	input  logic                        mem_ack,
	input  logic [`DC_DW-1:0]           mem_rdata,
	// Way selection
	dcache_way_if.ctrl                  way,
	// Arrays
	input  dcache_pkg::tag_entry_t      tag_rd [`DC_WAYS],
	input  logic [`DC_DW-1:0]           dat_rd [`DC_WAYS],
	output dcache_pkg::set_t            arr_set,
	output logic                        tag_wr,
	output logic                        dat_wr,
	output dcache_pkg::tag_entry_t      tag_wr_entry,
	output logic [`DC_DW-1:0]           dat_wr_entry
);

	mem_req_pkg::state_t state;
	mem_req_pkg::func_t  func_q;
	logic [`DC_AW-1:0]   addr_q;
	logic [`DC_DW-1:0]   wdata_q;
	dcache_pkg::tag_t    addr_tag;
	logic                store_op;
	logic                hit_c;
	dcache_pkg::way_t    rway_c;
	logic                hit_q;
	dcache_pkg::way_t    rway_q;
	logic                ack_q;
	logic [7:0]          lfsr_q;

	assign arr_set  = dcache_pkg::set_t'(addr_q);
	assign addr_tag = addr_q[`DC_AW-1:$bits(dcache_pkg::set_t)];
	assign store_op = (func_q == mem_req_pkg::MR_STORE) || (func_q == mem_req_pkg::MR_MOVST);

	// ====================
	// Tag compare
	// ====================

	// Nothing hits while the cache is turned off
	always_comb begin
		hit_c  = 1'b0;
		rway_c = '0;
		for (int i = 0; i < `DC_WAYS; i++) begin
			if (dce && tag_rd[i].valid && (tag_rd[i].tag == addr_tag)) begin
				hit_c  = 1'b1;
				rway_c = dcache_pkg::way_t'(i);
			end
		end
	end

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state   <= mem_req_pkg::IDLE;
			mem_req <= 1'b0;
			ack_q   <= 1'b0;
			hit_q   <= 1'b0;
			rway_q  <= '0;
			lfsr_q  <= '0;
		end else begin
			// XNOR feedback keeps the all-zero reset value inside the sequence
			lfsr_q  <= {lfsr_q[6:0], ~^{lfsr_q[7], lfsr_q[5], lfsr_q[4], lfsr_q[3]}};
			mem_req <= 1'b0;
			ack_q   <= 1'b0;
			case (state)
				mem_req_pkg::IDLE:
					if (req) state <= mem_req_pkg::LOOKUP;
				mem_req_pkg::LOOKUP: begin
					hit_q  <= hit_c;
					rway_q <= rway_c;
					// A load hit answers straight away, everything else goes to memory
					if (hit_c && !store_op) begin
						state <= mem_req_pkg::DONE;
					end else begin
						mem_req <= 1'b1;
						state   <= mem_req_pkg::MEMORY_REQ;
					end
				end
				mem_req_pkg::MEMORY_REQ:
					if (mem_ack) begin
						ack_q <= 1'b1;
						state <= mem_req_pkg::MEMORY_ACK;
					end
				mem_req_pkg::MEMORY_ACK:
					if (store_op && hit_q)
						state <= mem_req_pkg::REFILL;
					else if (!store_op && dce)
						state <= mem_req_pkg::FILL;
					else
						state <= mem_req_pkg::DONE;
				// Gives the selector one edge to load the LFSR way
				mem_req_pkg::FILL:   state <= mem_req_pkg::REFILL;
				mem_req_pkg::REFILL: state <= mem_req_pkg::DONE;
				default:             state <= mem_req_pkg::IDLE;
			endcase
		end
	end

	// Request and response payload, qualified by the state machine
	always_ff @(posedge clk) begin
		if ((state == mem_req_pkg::IDLE) && req) begin
			func_q  <= func;
			addr_q  <= addr;
			wdata_q <= wdata;
		end
		if (state == mem_req_pkg::LOOKUP) begin
			rdata     <= dat_rd[rway_c];
			mem_we    <= store_op;
			mem_addr  <= addr_q;
			mem_wdata <= wdata_q;
		end
		if ((state == mem_req_pkg::MEMORY_REQ) && mem_ack && !store_op) rdata <= mem_rdata;
	end

	// ====================
	// Outputs
	// ====================

	assign done = (state == mem_req_pkg::DONE);
	assign hit  = hit_q;

	// REFILL writes at wway, the store data on a store hit or the fetched word on a load
	assign dat_wr       = (state == mem_req_pkg::REFILL);
	assign tag_wr       = (state == mem_req_pkg::REFILL) && !store_op;
	assign dat_wr_entry = store_op ? wdata_q : rdata;
	assign tag_wr_entry = '{valid: 1'b1, tag: addr_tag};

	assign way.state = state;
	assign way.func  = func_q;
	assign way.hit   = hit_q;
	assign way.rway  = rway_q;
	assign way.ack   = ack_q;
	assign way.wr_dc = (state == mem_req_pkg::FILL);
	assign way.lfsr  = dcache_pkg::way_t'(lfsr_q);

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
// Data cache top level tying the controller, way selector and tag and data arrays to plain ports
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               dce,
	input  logic               req,
	input  mem_req_pkg::func_t func,
	input  logic [`DC_AW-1:0]  addr,
	input  logic [`DC_DW-1:0]  wdata,
	output logic               done,
	output logic [`DC_DW-1:0]  rdata,
	output logic               hit,
	output logic               mem_req,
	output logic               mem_we,
	output logic [`DC_AW-1:0]  mem_addr,
	output logic [`DC_DW-1:0]  mem_wdata,
	input  logic               mem_ack,
	input  logic [`DC_DW-1:0]  mem_rdata
);

	dcache_pkg::tag_entry_t tag_rd [`DC_WAYS];
	logic [`DC_DW-1:0]      dat_rd [`DC_WAYS];
	dcache_pkg::set_t       arr_set;
	logic                   tag_wr;
	logic                   dat_wr;
	dcache_pkg::tag_entry_t tag_wr_entry;
	logic [`DC_DW-1:0]      dat_wr_entry;

	dcache_way_if way_if_i ();

	dcache_ctrl dcache_ctrl_i (
		.clk, .rst, .dce, .req, .func, .addr, .wdata, .done, .rdata, .hit,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
		.way(way_if_i.ctrl),
		.tag_rd, .dat_rd, .arr_set, .tag_wr, .dat_wr, .tag_wr_entry, .dat_wr_entry
	);

	dcache_way_select dcache_way_select_i (.clk, .rst, .way(way_if_i.selector));

	// Both arrays share the set index and the write way
	dcache_way_array #(.entry_t(dcache_pkg::tag_entry_t)) tag_array (
		.clk, .rst, .set(arr_set), .wr(tag_wr), .wr_way(way_if_i.wway),
		.wr_entry(tag_wr_entry), .rd_entries(tag_rd)
	);

	dcache_way_array #(.entry_t(logic [`DC_DW-1:0])) data_array (
		.clk, .rst, .set(arr_set), .wr(dat_wr), .wr_way(way_if_i.wway),
		.wr_entry(dat_wr_entry), .rd_entries(dat_rd)
	);

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
// Self-checking testbench for the data cache, replays the access list in dv/dcache_stim.txt
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Word a of the backing memory starts out as a times this value
	localparam logic [`DC_DW-1:0] MEM_FILL = 32'h0001_0001;
	// Value of the hit column that leaves the hit flag unchecked
	localparam int HIT_ANY = 2;
	// Longest an access may take before it is given up
	localparam int ACCESS_CYCLES = 40;

	// One line of the stimulus file
	typedef struct {
		int                line;
		logic [6:0]        op;
		logic [`DC_AW-1:0] addr;
		logic [`DC_DW-1:0] wdata;
		logic [`DC_DW-1:0] rdata;
		int                hit;
		logic              en;
	} access_t;

	logic               clk;
	logic               rst;
	logic               dce;
	logic               req;
	mem_req_pkg::func_t func;
	logic [`DC_AW-1:0]  addr;
	logic [`DC_DW-1:0]  wdata;
	logic               done;
	logic [`DC_DW-1:0]  rdata;
	logic               hit;
	logic               mem_req;
	logic               mem_we;
	logic [`DC_AW-1:0]  mem_addr;
	logic [`DC_DW-1:0]  mem_wdata;
	logic               mem_ack = 1'b0;
	logic [`DC_DW-1:0]  mem_rdata = '0;

	access_t           accesses [$];
	logic [`DC_DW-1:0] mem_model [1 << `DC_AW];
	logic [15:0]       lfsr_state = 16'd64;
	int                errors = 0;
	int                checks = 0;
	int                req_count = 0;
	bit                stim_loaded = 1'b0;
	string             test_name = "reset";
	// Request being served, used to check the memory writes
	bit                cur_store = 1'b0;
	logic [`DC_AW-1:0] cur_addr = '0;
	logic [`DC_DW-1:0] cur_wdata = '0;

	dcache_top dcache_top_i (
		.clk, .rst, .dce, .req, .func, .addr, .wdata, .done, .rdata, .hit,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
	);

	always #5 clk = ~clk;

	// ====================
	// Helpers
	// ====================

	// Galois LFSR, polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = {1'b0, s[15:1]};
		if (s[0]) begin
			lfsr_next = lfsr_next ^ 16'hB400;
		end
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	// Lines starting with # are column notes
	task automatic read_stim();
		int      fd;
		int      n;
		int      line_no;
		string   line;
		access_t acc;
		fd = $fopen("dv/dcache_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("The stimulus file dv/dcache_stim.txt could not be opened");
			return;
		end
		line_no = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			line_no++;
			if (line.len() > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %d %h",
					acc.op, acc.addr, acc.wdata, acc.rdata, acc.hit, acc.en);
				acc.line = line_no;
				if (n == 6) accesses.push_back(acc);
			end
		end
		$fclose(fd);
	endtask

	// Issues one request and checks the response once done arrives
	task automatic run_access(input access_t a);
		int cycles;
		bit is_store;
		bit want_hit;
		is_store = (a.op == mem_req_pkg::MR_STORE) || (a.op == mem_req_pkg::MR_MOVST);
		test_name = $sformatf("line %0d %s 0x%h", a.line, is_store ? "store" : "load", a.addr);
		cur_store = is_store;
		cur_addr = a.addr;
		cur_wdata = a.wdata;
		req_count = 0;
		dce = a.en;
		func = a.op;
		addr = a.addr;
		wdata = a.wdata;
		req = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			req = 1'b0;
			cycles++;
		end while (!done && cycles < ACCESS_CYCLES);
		if (!done) begin
			errors++;
			$display("%s: done did not arrive within %0d cycles", test_name, ACCESS_CYCLES);
		end else begin
			// A hit is impossible with the cache off
			want_hit = (a.hit == HIT_ANY) ? hit : (a.hit == 1) && a.en;
			if (a.hit != HIT_ANY) check_value("hit", want_hit, hit);
			if (!is_store) check_value("rdata", a.rdata, rdata);
			// Only a load hit stays off the memory bus
			if (!is_store && want_hit) begin
				check_value("mem_req count", 0, req_count);
				check_value("latency", 2, cycles);
			end else begin
				check_value("mem_req count", 1, req_count);
			end
			// Write-through puts every store into memory
			if (is_store) check_value("memory word", a.wdata, mem_model[a.addr]);
		end
		// DONE returns to IDLE on the next edge
		@(negedge clk);
	endtask

	// ====================
	// Backing memory
	// ====================

	// Answers each request after 1 to 4 cycles and applies the write at the acknowledge
	always @(negedge clk) begin : memory_model
		logic b0;
		logic b1;
		int   ack_wait;
		logic             pend_we;
		logic [`DC_AW-1:0] pend_addr;
		logic [`DC_DW-1:0] pend_wdata;
		mem_ack <= 1'b0;
		if (ack_wait > 0) begin
			ack_wait--;
			if (ack_wait == 0) begin
				if (pend_we) mem_model[pend_addr] = pend_wdata;
				mem_rdata <= mem_model[pend_addr];
				mem_ack <= 1'b1;
			end
		end
		if (mem_req) begin
			req_count++;
			pend_we = mem_we;
			pend_addr = mem_addr;
			pend_wdata = mem_wdata;
			take_bit(b0);
			take_bit(b1);
			ack_wait = 1 + int'({b1, b0});
			check_value("mem_we", cur_store, mem_we);
			// A memory write carries the request that caused it
			if (mem_we) begin
				check_value("mem_addr", cur_addr, mem_addr);
				check_value("mem_wdata", cur_wdata, mem_wdata);
			end
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		clk = 1'b0;
		rst = 1'b1;
		dce = 1'b0;
		req = 1'b0;
		func = '0;
		addr = '0;
		wdata = '0;
		for (int a = 0; a < (1 << `DC_AW); a++) begin
			mem_model[a] = a * MEM_FILL;
		end
		read_stim();
		if (accesses.size() == 0) begin
			errors++;
			$display("No accesses were found in the stimulus file");
		end else begin
			stim_loaded = 1'b1;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		foreach (accesses[i]) begin
			run_access(accesses[i]);
		end
		$display("Summary: %0d checks, %0d errors over %0d accesses",
			checks, errors, accesses.size());
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Twenty cycles per access is far more than the slowest miss needs
	initial begin : watchdog
		wait (stim_loaded);
		repeat (accesses.size() * 20) @(posedge clk);
		$display("The watchdog expired after %0d cycles, the accesses did not complete",
			accesses.size() * 20);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/dcache_stim.txt */
# op addr wdata exp_rdata exp_hit enable, hex except exp_hit which is decimal
# op 00 load, 01 store, 02 move-store; exp_hit 2 leaves hit unchecked; exp_rdata unused on stores
00 010 00000000 00100010 0 1
00 010 00000000 00100010 1 1
00 025 00000000 00250025 0 1
01 025 cafe0001 00000000 1 1
00 025 00000000 cafe0001 1 1
01 033 beef0033 00000000 0 1
00 033 00000000 beef0033 0 1
00 033 00000000 beef0033 1 1
02 033 a5a50033 00000000 1 1
00 033 00000000 a5a50033 1 1
00 102 00000000 01020102 0 1
00 102 00000000 01020102 1 1
00 206 00000000 02060206 0 1
00 206 00000000 02060206 1 1
00 30a 00000000 030a030a 0 1
00 30a 00000000 030a030a 1 1
00 00e 00000000 000e000e 0 1
00 00e 00000000 000e000e 1 1
00 1f2 00000000 01f201f2 2 1
00 102 00000000 01020102 2 1
00 206 00000000 02060206 2 1
00 30a 00000000 030a030a 2 1
00 00e 00000000 000e000e 2 1
00 1f2 00000000 01f201f2 2 1
00 010 00000000 00100010 0 0
01 0c1 12345678 00000000 0 0
00 0c1 00000000 12345678 0 0
00 0c1 00000000 12345678 0 1
00 0c1 00000000 12345678 1 1

/* project.f */
+incdir+hdl
hdl/mem_req_pkg.sv
hdl/dcache_pkg.sv
hdl/dcache_way_if.sv
hdl/dcache_way_array.sv
hdl/dcache_way_select.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
